// File: source/pinmux_reg_pkg.sv
/*
  Shared widths, register indices and reset values for the global and
  pin-mux register block. Modules import it inside their bodies.
*/
`default_nettype none

package pinmux_reg_pkg;

  // ------------------------------
  // Bus geometry
  // ------------------------------
  localparam int data_w = 32;
  localparam int be_w   = 4;
  localparam int addr_w = 8;
  // Word index sits in address bits 6:2
  localparam int idx_w  = 5;
  // One write strobe per word index
  localparam int reg_cnt = 2 ** idx_w;

  typedef logic [data_w-1:0] reg_data_t;
  typedef logic [be_w-1:0]   reg_be_t;

  // Register map, word indices
  // Holes in the map read zero
  typedef enum logic [idx_w-1:0] {
    idx_chip_id   = 5'd0,
    idx_glbl_rst  = 5'd1,
    idx_glbl_mask = 5'd3,
    idx_glbl_stat = 5'd4,
    idx_gpio_in   = 5'd5,
    idx_gpio_out  = 5'd6,
    idx_gpio_dir  = 5'd7,
    idx_gpio_stat = 5'd9,
    idx_gpio_set  = 5'd10,
    idx_gpio_mask = 5'd11
  } reg_idx_e;

  // ------------------------------
  // Constants
  // ------------------------------
  // Manufacturer 8268, one core, chip 3, rev 01
  localparam reg_data_t chip_id_value = 32'h8268_1301;

  // Sticky hardware sources in status byte 1
  localparam int hw_intr_w   = 8;
  // Software bits 19:16 of global status
  localparam int soft_intr_w = 4;

endpackage

`default_nettype wire

// File: source/pinmux_reg_bus.sv
/*
  Register bus slave. Decodes the word index, returns a one-cycle
  acknowledge with the registered read data, and hands write strobes
  to the register banks.
*/
`default_nettype none
`timescale 1ns/100ps

module pinmux_reg_bus (
  input  logic                                mclk,
  input  logic                                h_reset_n,
  input  logic                                reg_cs,
  input  logic                                reg_wr,
  input  logic [pinmux_reg_pkg::addr_w-1:0]   reg_addr,
  input  pinmux_reg_pkg::reg_data_t           reg_wdata,
  input  pinmux_reg_pkg::reg_be_t             reg_be,
  input  pinmux_reg_pkg::reg_data_t           glbl_rdata,
  input  pinmux_reg_pkg::reg_data_t           gpio_rdata,
  output pinmux_reg_pkg::reg_data_t           reg_rdata,
  output logic                                reg_ack,
  output logic [pinmux_reg_pkg::reg_cnt-1:0]  wr_stb,
  output logic [pinmux_reg_pkg::reg_cnt-1:0]  wr_commit,
  output pinmux_reg_pkg::reg_be_t             wr_be,
  output pinmux_reg_pkg::reg_data_t           wr_data,
  output pinmux_reg_pkg::reg_idx_e            rd_idx
);
  import pinmux_reg_pkg::*;

  logic [idx_w-1:0] word_idx;

  // Byte offset bits are not part of the index
  assign word_idx = reg_addr[idx_w+1:2];
  assign rd_idx   = reg_idx_e'(word_idx);

  // Write data and lanes go straight to the banks
  assign wr_data = reg_wdata;
  assign wr_be   = reg_be;

  // ------------------------------
  // Write decode
  // ------------------------------
  // Level, high for the whole request
  always_comb begin
    wr_stb = '0;
    if (reg_cs && reg_wr) begin
      wr_stb[word_idx] = 1'b1;
    end
  end

  // Only in the ack cycle, so status bits see one clear per access
  assign wr_commit = wr_stb & {reg_cnt{reg_ack}};

  // ------------------------------
  // Acknowledge and read capture
  // ------------------------------
  // Ack on first edge with cs high and ack low, then drop
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      reg_ack   <= 1'b0;
      reg_rdata <= '0;
    end else if (reg_cs && !reg_ack) begin
      reg_ack <= 1'b1;
      // Each bank returns zero outside its own indices
      reg_rdata <= glbl_rdata | gpio_rdata;
    end else begin
      reg_ack <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: source/intr_stat_reg.sv
/*
  Sticky interrupt status bits. Software clears a bit by writing one
  under its enable; a hardware request in the same cycle keeps it set.
*/
`default_nettype none
`timescale 1ns/100ps

module intr_stat_reg #(
  parameter int width = 8
) (
  input  logic             mclk,
  input  logic             h_reset_n,
  input  logic [width-1:0] clr_en,
  input  logic [width-1:0] clr_data,
  input  logic [width-1:0] hw_set,
  output logic [width-1:0] status
);

  logic [width-1:0] clr_mask;

  // Write-one-to-clear, only on enabled bits
  assign clr_mask = clr_en & clr_data;

  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      status <= '0;
    end else begin
      // Set applied last so it wins over clear
      status <= (status & ~clr_mask) | hw_set;
    end
  end

endmodule

`default_nettype wire

// File: source/glbl_ctrl_regs.sv
/*
  Global control bank: chip id, peripheral reset control and the
  global interrupt mask and status pair that drive the CPU interrupt lines.
*/
`default_nettype none
`timescale 1ns/100ps

module glbl_ctrl_regs (
  input  logic                                mclk,
  input  logic                                h_reset_n,
  input  logic [pinmux_reg_pkg::reg_cnt-1:0]  wr_stb,
  input  logic [pinmux_reg_pkg::reg_cnt-1:0]  wr_commit,
  input  pinmux_reg_pkg::reg_be_t             wr_be,
  input  pinmux_reg_pkg::reg_data_t           wr_data,
  input  pinmux_reg_pkg::reg_idx_e            rd_idx,
  input  logic [1:0]                          ext_intr_in,
  input  logic                                usb_intr,
  input  logic                                i2cm_intr,
  input  logic                                gpio_intr,
  input  logic [2:0]                          timer_intr,
  output pinmux_reg_pkg::reg_data_t           glbl_rdata,
  output logic [1:0]                          cpu_core_rst_n,
  output logic                                cpu_intf_rst_n,
  output logic                                qspim_rst_n,
  output logic                                sspim_rst_n,
  output logic                                i2cm_rst_n,
  output logic                                usb_rst_n,
  output logic [1:0]                          uart_rst_n,
  output logic [15:0]                         irq_lines,
  output logic                                soft_irq,
  output logic [2:0]                          user_irq
);
  import pinmux_reg_pkg::*;

  reg_data_t              rst_ctrl;
  reg_data_t              intr_mask;
  reg_data_t              intr_stat;
  logic [7:0]             stat_plain;
  logic [hw_intr_w-1:0]   stat_hw;
  logic [hw_intr_w-1:0]   hw_req;
  logic [soft_intr_w-1:0] stat_soft;

  // ------------------------------
  // Reset control and mask
  // ------------------------------
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      rst_ctrl   <= '0;
      intr_mask  <= '0;
      stat_plain <= '0;
      stat_soft  <= '0;
    end else begin
      for (int b = 0; b < be_w; b++) begin
        if (wr_stb[idx_glbl_rst] && wr_be[b]) begin
          rst_ctrl[b*8 +: 8] <= wr_data[b*8 +: 8];
        end
        if (wr_stb[idx_glbl_mask] && wr_be[b]) begin
          intr_mask[b*8 +: 8] <= wr_data[b*8 +: 8];
        end
      end
      // Status byte 0 and soft bits are plain storage
      if (wr_stb[idx_glbl_stat] && wr_be[0]) begin
        stat_plain <= wr_data[7:0];
      end
      if (wr_stb[idx_glbl_stat] && wr_be[2]) begin
        stat_soft <= wr_data[16 +: soft_intr_w];
      end
    end
  end

  // Active-low resets, cleared register holds peripherals in reset
  assign cpu_intf_rst_n = rst_ctrl[0];
  assign qspim_rst_n    = rst_ctrl[1];
  assign sspim_rst_n    = rst_ctrl[2];
  assign uart_rst_n[0]  = rst_ctrl[3];
  assign i2cm_rst_n     = rst_ctrl[4];
  assign usb_rst_n      = rst_ctrl[5];
  assign uart_rst_n[1]  = rst_ctrl[6];
  assign cpu_core_rst_n = rst_ctrl[9:8];

  // ------------------------------
  // Interrupt status
  // ------------------------------
  // Byte 1 sources, msb first
  assign hw_req = {gpio_intr, ext_intr_in, usb_intr, i2cm_intr, timer_intr};

  intr_stat_reg #(
    .width (hw_intr_w)
  ) stat_hw_inst (
    .mclk      (mclk),
    .h_reset_n (h_reset_n),
    .clr_en    ({hw_intr_w{wr_commit[idx_glbl_stat] & wr_be[1]}}),
    .clr_data  (wr_data[15:8]),
    .hw_set    (hw_req),
    .status    (stat_hw)
  );

  assign intr_stat = {{(data_w - 8 - hw_intr_w - soft_intr_w){1'b0}},
                      stat_soft, stat_hw, stat_plain};

  // Masked outputs to the CPU
  assign irq_lines = intr_stat[15:0] & intr_mask[15:0];
  assign soft_irq  = intr_stat[16] & intr_mask[16];
  assign user_irq  = intr_stat[19:17] & intr_mask[19:17];

  // Read back, zero for indices owned elsewhere
  always_comb begin
    case (rd_idx)
      idx_chip_id:   glbl_rdata = chip_id_value;
      idx_glbl_rst:  glbl_rdata = rst_ctrl;
      idx_glbl_mask: glbl_rdata = intr_mask;
      idx_glbl_stat: glbl_rdata = intr_stat;
      default:       glbl_rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: source/gpio_regs.sv
/*
  GPIO bank: input synchroniser, output data and direction, and the
  interrupt status with its set alias and mask forming gpio_intr.
*/
`default_nettype none
`timescale 1ns/100ps

module gpio_regs (
  input  logic                                mclk,
  input  logic                                h_reset_n,
  input  logic [pinmux_reg_pkg::reg_cnt-1:0]  wr_stb,
  input  logic [pinmux_reg_pkg::reg_cnt-1:0]  wr_commit,
  input  pinmux_reg_pkg::reg_be_t             wr_be,
  input  pinmux_reg_pkg::reg_data_t           wr_data,
  input  pinmux_reg_pkg::reg_idx_e            rd_idx,
  input  pinmux_reg_pkg::reg_data_t           gpio_in_data,
  input  pinmux_reg_pkg::reg_data_t           gpio_int_event,
  output pinmux_reg_pkg::reg_data_t           gpio_rdata,
  output pinmux_reg_pkg::reg_data_t           cfg_gpio_data_in,
  output pinmux_reg_pkg::reg_data_t           gpio_prev_indata,
  output pinmux_reg_pkg::reg_data_t           cfg_gpio_out_data,
  output pinmux_reg_pkg::reg_data_t           cfg_gpio_dir_sel,
  output logic                                gpio_intr
);
  import pinmux_reg_pkg::*;

  reg_data_t in_s1;
  reg_data_t in_s2;
  reg_data_t in_reg;
  reg_data_t out_reg;
  reg_data_t dir_reg;
  reg_data_t mask_reg;
  reg_data_t stat_reg;
  reg_data_t stat_clr_en;
  reg_data_t stat_set;

  // ------------------------------
  // Pin synchroniser
  // ------------------------------
  // Two sync stages, third is the readable copy
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      in_s1  <= '0;
      in_s2  <= '0;
      in_reg <= '0;
    end else begin
      in_s1  <= gpio_in_data;
      in_s2  <= in_s1;
      in_reg <= in_s2;
    end
  end

  // Previous sample kept for edge detection downstream
  assign gpio_prev_indata = in_s2;
  assign cfg_gpio_data_in = in_reg;

  // Output, direction and mask, byte lane writes
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      out_reg  <= '0;
      dir_reg  <= '0;
      mask_reg <= '0;
    end else begin
      for (int b = 0; b < be_w; b++) begin
        if (wr_stb[idx_gpio_out] && wr_be[b]) begin
          out_reg[b*8 +: 8] <= wr_data[b*8 +: 8];
        end
        if (wr_stb[idx_gpio_dir] && wr_be[b]) begin
          dir_reg[b*8 +: 8] <= wr_data[b*8 +: 8];
        end
        if (wr_stb[idx_gpio_mask] && wr_be[b]) begin
          mask_reg[b*8 +: 8] <= wr_data[b*8 +: 8];
        end
      end
    end
  end

  assign cfg_gpio_out_data = out_reg;
  assign cfg_gpio_dir_sel  = dir_reg;

  // ------------------------------
  // Interrupt status
  // ------------------------------
  // Clear enable per byte lane, lane 3 for the top byte
  always_comb begin
    for (int b = 0; b < be_w; b++) begin
      stat_clr_en[b*8 +: 8] = {8{wr_commit[idx_gpio_stat] & wr_be[b]}};
    end
  end

  // Pin events plus software set alias, all lanes
  assign stat_set = gpio_int_event | ({data_w{wr_commit[idx_gpio_set]}} & wr_data);

  intr_stat_reg #(
    .width (data_w)
  ) stat_inst (
    .mclk      (mclk),
    .h_reset_n (h_reset_n),
    .clr_en    (stat_clr_en),
    .clr_data  (wr_data),
    .hw_set    (stat_set),
    .status    (stat_reg)
  );

  // Any unmasked pending bit
  assign gpio_intr = |(stat_reg & mask_reg);

  always_comb begin
    case (rd_idx)
      idx_gpio_in:   gpio_rdata = in_reg;
      idx_gpio_out:  gpio_rdata = out_reg;
      idx_gpio_dir:  gpio_rdata = dir_reg;
      // Set alias reads back the status
      idx_gpio_stat,
      idx_gpio_set:  gpio_rdata = stat_reg;
      idx_gpio_mask: gpio_rdata = mask_reg;
      default:       gpio_rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: source/pinmux_reg.sv
/*
  Top of the global and pin-mux register block. Connects the register
  bus slave to the global control and GPIO banks.
*/
`default_nettype none
`timescale 1ns/100ps

module pinmux_reg (
  input  logic                               mclk,
  input  logic                               h_reset_n,
  // Peripheral resets, active low
  output logic [1:0]                         cpu_core_rst_n,
  output logic                               cpu_intf_rst_n,
  output logic                               qspim_rst_n,
  output logic                               sspim_rst_n,
  output logic [1:0]                         uart_rst_n,
  output logic                               i2cm_rst_n,
  output logic                               usb_rst_n,
  // Register bus
  input  logic                               reg_cs,
  input  logic                               reg_wr,
  input  logic [pinmux_reg_pkg::addr_w-1:0]  reg_addr,
  input  pinmux_reg_pkg::reg_data_t          reg_wdata,
  input  pinmux_reg_pkg::reg_be_t            reg_be,
  output pinmux_reg_pkg::reg_data_t          reg_rdata,
  output logic                               reg_ack,
  // Interrupts
  input  logic [1:0]                         ext_intr_in,
  input  logic                               usb_intr,
  input  logic                               i2cm_intr,
  input  logic [2:0]                         timer_intr,
  output logic [15:0]                        irq_lines,
  output logic                               soft_irq,
  output logic [2:0]                         user_irq,
  // GPIO
  input  pinmux_reg_pkg::reg_data_t          gpio_in_data,
  input  pinmux_reg_pkg::reg_data_t          gpio_int_event,
  output pinmux_reg_pkg::reg_data_t          cfg_gpio_out_data,
  output pinmux_reg_pkg::reg_data_t          cfg_gpio_data_in,
  output pinmux_reg_pkg::reg_data_t          cfg_gpio_dir_sel,
  output pinmux_reg_pkg::reg_data_t          gpio_prev_indata
);
  import pinmux_reg_pkg::*;

  logic [reg_cnt-1:0] wr_stb;
  logic [reg_cnt-1:0] wr_commit;
  reg_be_t            wr_be;
  reg_data_t          wr_data;
  reg_idx_e           rd_idx;
  reg_data_t          glbl_rdata;
  reg_data_t          gpio_rdata;
  // GPIO bank feeds a global status source
  logic               gpio_intr;

  pinmux_reg_bus bus_inst (
    .mclk       (mclk),
    .h_reset_n  (h_reset_n),
    .reg_cs     (reg_cs),
    .reg_wr     (reg_wr),
    .reg_addr   (reg_addr),
    .reg_wdata  (reg_wdata),
    .reg_be     (reg_be),
    .glbl_rdata (glbl_rdata),
    .gpio_rdata (gpio_rdata),
    .reg_rdata  (reg_rdata),
    .reg_ack    (reg_ack),
    .wr_stb     (wr_stb),
    .wr_commit  (wr_commit),
    .wr_be      (wr_be),
    .wr_data    (wr_data),
    .rd_idx     (rd_idx)
  );

  glbl_ctrl_regs glbl_inst (
    .mclk           (mclk),
    .h_reset_n      (h_reset_n),
    .wr_stb         (wr_stb),
    .wr_commit      (wr_commit),
    .wr_be          (wr_be),
    .wr_data        (wr_data),
    .rd_idx         (rd_idx),
    .ext_intr_in    (ext_intr_in),
    .usb_intr       (usb_intr),
    .i2cm_intr      (i2cm_intr),
    .gpio_intr      (gpio_intr),
    .timer_intr     (timer_intr),
    .glbl_rdata     (glbl_rdata),
    .cpu_core_rst_n (cpu_core_rst_n),
    .cpu_intf_rst_n (cpu_intf_rst_n),
    .qspim_rst_n    (qspim_rst_n),
    .sspim_rst_n    (sspim_rst_n),
    .i2cm_rst_n     (i2cm_rst_n),
    .usb_rst_n      (usb_rst_n),
    .uart_rst_n     (uart_rst_n),
    .irq_lines      (irq_lines),
    .soft_irq       (soft_irq),
    .user_irq       (user_irq)
  );

  gpio_regs gpio_inst (
    .mclk              (mclk),
    .h_reset_n         (h_reset_n),
    .wr_stb            (wr_stb),
    .wr_commit         (wr_commit),
    .wr_be             (wr_be),
    .wr_data           (wr_data),
    .rd_idx            (rd_idx),
    .gpio_in_data      (gpio_in_data),
    .gpio_int_event    (gpio_int_event),
    .gpio_rdata        (gpio_rdata),
    .cfg_gpio_data_in  (cfg_gpio_data_in),
    .gpio_prev_indata  (gpio_prev_indata),
    .cfg_gpio_out_data (cfg_gpio_out_data),
    .cfg_gpio_dir_sel  (cfg_gpio_dir_sel),
    .gpio_intr         (gpio_intr)
  );

endmodule

`default_nettype wire

// File: tests/pinmux_reg_assertions.sv
/*
  Bus protocol and interrupt masking checks, bound into the register
  block top so every simulation of pinmux_reg carries them.
*/
`default_nettype none
`timescale 1ns/100ps

module pinmux_reg_assertions (
  input logic                               mclk,
  input logic                               h_reset_n,
  input logic                               reg_cs,
  input logic                               reg_wr,
  input logic [pinmux_reg_pkg::addr_w-1:0]  reg_addr,
  input pinmux_reg_pkg::reg_data_t          reg_wdata,
  input pinmux_reg_pkg::reg_be_t            reg_be,
  input logic                               reg_ack,
  input logic [15:0]                        irq_lines
);
  import pinmux_reg_pkg::*;

  reg_data_t mask_model;

  // ------------------------------
  // Bus protocol
  // ------------------------------
  // Ack is a single-cycle pulse
  ack_one_cycle: assert property (
    @(posedge mclk) disable iff (!h_reset_n) reg_ack |=> !reg_ack
  ) else $error("reg_ack stayed high for two cycles");

  // No ack without a request on the previous edge
  ack_after_cs: assert property (
    @(posedge mclk) disable iff (!h_reset_n) reg_ack |-> $past(reg_cs)
  ) else $error("reg_ack rose without reg_cs");

  // ------------------------------
  // Interrupt masking
  // ------------------------------
  // Mask as written over the bus, enabled lanes only
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      mask_model <= '0;
    end else if (reg_cs && reg_wr && reg_addr[idx_w+1:2] == idx_glbl_mask) begin
      for (int b = 0; b < be_w; b++) begin
        if (reg_be[b]) begin
          mask_model[b*8 +: 8] <= reg_wdata[b*8 +: 8];
        end
      end
    end
  end

  irq_masked: assert property (
    @(posedge mclk) disable iff (!h_reset_n) (irq_lines & ~mask_model[15:0]) == 16'h0000
  ) else $error("irq_lines active on a masked bit");

endmodule

// Watches the external bus and the interrupt lines
bind pinmux_reg pinmux_reg_assertions assertions_inst (
  .mclk      (mclk),
  .h_reset_n (h_reset_n),
  .reg_cs    (reg_cs),
  .reg_wr    (reg_wr),
  .reg_addr  (reg_addr),
  .reg_wdata (reg_wdata),
  .reg_be    (reg_be),
  .reg_ack   (reg_ack),
  .irq_lines (irq_lines)
);

`default_nettype wire

// File: tests/tb_pinmux_reg.sv
/*
  Table-driven testbench for the register block. Each step is a bus
  access, a pin pattern or an interrupt pulse, followed by checks of
  read data, reset outputs and interrupt outputs.
*/
`default_nettype none
`timescale 1ns/100ps

module tb_pinmux_reg;
  import pinmux_reg_pkg::*;

  localparam int reset_cycles    = 10;
  localparam int cycles_per_step = 40;

  typedef enum logic [2:0] {op_read, op_write, op_pins, op_gpio_evt, op_usb_evt} op_e;

  // One table row, name kept in a parallel queue
  typedef struct packed {
    op_e              op;
    logic [idx_w-1:0] idx;
    reg_be_t          be;
    reg_data_t        data;
    reg_data_t        exp_rdata;
    logic [9:0]       exp_rst;
    logic [20:0]      exp_irq;
  } step_t;

  logic             mclk;
  logic             h_reset_n;
  logic             reg_cs;
  logic             reg_wr;
  logic [addr_w-1:0] reg_addr;
  reg_data_t        reg_wdata;
  reg_be_t          reg_be;
  reg_data_t        reg_rdata;
  logic             reg_ack;
  logic [1:0]       cpu_core_rst_n;
  logic             cpu_intf_rst_n;
  logic             qspim_rst_n;
  logic             sspim_rst_n;
  logic [1:0]       uart_rst_n;
  logic             i2cm_rst_n;
  logic             usb_rst_n;
  logic [1:0]       ext_intr_in;
  logic             usb_intr;
  logic             i2cm_intr;
  logic [2:0]       timer_intr;
  logic [15:0]      irq_lines;
  logic             soft_irq;
  logic [2:0]       user_irq;
  reg_data_t        gpio_in_data;
  reg_data_t        gpio_int_event;
  reg_data_t        cfg_gpio_out_data;
  reg_data_t        cfg_gpio_data_in;
  reg_data_t        cfg_gpio_dir_sel;
  reg_data_t        gpio_prev_indata;

  step_t steps[$];
  string step_names[$];
  int    cycle_count = 0;
  int    cycle_limit = 0;

  pinmux_reg pinmux_reg_inst (.*);

  initial begin
    mclk = 1'b0;
    forever #4 mclk = ~mclk;
  end

  // Timeout watchdog
  always @(posedge mclk) begin
    cycle_count++;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      abort_run("timeout: the table did not finish within the cycle limit");
    end
  end

  // ------------------------------
  // Helpers
  // ------------------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("FAIL: see errors above");
    $fatal(1, "run stopped");
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Same bit order as the reset control register, bit 7 unused
  function automatic logic [9:0] rst_vector();
    return {cpu_core_rst_n, 1'b0, uart_rst_n[1], usb_rst_n, i2cm_rst_n,
            uart_rst_n[0], sspim_rst_n, qspim_rst_n, cpu_intf_rst_n};
  endfunction

  // gpio_intr on top, then user, soft and the 16 lines
  function automatic logic [20:0] irq_vector();
    return {pinmux_reg_inst.gpio_intr, user_irq, soft_irq, irq_lines};
  endfunction

  task automatic check_data(input string name, input reg_data_t exp_val,
                            input reg_data_t act_val);
    if (act_val !== exp_val) begin
      $display("MISMATCH %s: expected %h actual %h", name, exp_val, act_val);
      abort_run("register data check failed");
    end
  endtask

  task automatic check_resets(input string name, input logic [9:0] exp_val,
                              input logic [9:0] act_val);
    if (act_val !== exp_val) begin
      $display("MISMATCH %s resets: expected %h actual %h", name, exp_val, act_val);
      abort_run("reset output check failed");
    end
  endtask

  task automatic check_irqs(input string name, input logic [20:0] exp_val,
                            input logic [20:0] act_val);
    if (act_val !== exp_val) begin
      $display("MISMATCH %s irqs: expected %h actual %h", name, exp_val, act_val);
      abort_run("interrupt output check failed");
    end
  endtask

  // ------------------------------
  // Stimulus tasks
  // ------------------------------
  task automatic bus_access(input logic wr, input logic [idx_w-1:0] idx, input reg_be_t be,
                            input reg_data_t data, output reg_data_t rdata);
    @(posedge mclk);
    #1;
    reg_cs    = 1'b1;
    reg_wr    = wr;
    reg_addr  = {1'b0, idx, 2'b00};
    reg_wdata = data;
    reg_be    = be;
    @(posedge mclk);
    #1;
    while (!reg_ack) begin
      @(posedge mclk);
      #1;
    end
    rdata = reg_rdata;
    // Held through the edge ending ack, status writes commit there
    @(posedge mclk);
    #1;
    reg_cs = 1'b0;
    reg_wr = 1'b0;
  endtask

  task automatic drive_pins(input reg_data_t pattern);
    @(posedge mclk);
    #1;
    gpio_in_data = pattern;
    // Two edges fill the second sync stage
    repeat (2) @(posedge mclk);
    #1;
  endtask

  task automatic pulse_gpio_event(input reg_data_t bits);
    @(posedge mclk);
    #1;
    gpio_int_event = bits;
    @(posedge mclk);
    #1;
    gpio_int_event = '0;
  endtask

  task automatic pulse_usb();
    @(posedge mclk);
    #1;
    usb_intr = 1'b1;
    @(posedge mclk);
    #1;
    usb_intr = 1'b0;
  endtask

  task automatic add_step(input string name, input op_e op, input logic [idx_w-1:0] idx,
                          input reg_be_t be, input reg_data_t data, input reg_data_t exp_rdata,
                          input logic [9:0] exp_rst, input logic [20:0] exp_irq);
    step_t s;
    s = '{op, idx, be, data, exp_rdata, exp_rst, exp_irq};
    steps.push_back(s);
    step_names.push_back(name);
  endtask

  // ------------------------------
  // Test table
  // ------------------------------
  task automatic build_table();
    reg_data_t   pins_a;
    reg_data_t   pins_b;
    logic [9:0]  rst_on;
    logic [20:0] gpio_on;
    pins_a  = lcg_next(32'h3cb12b28);
    pins_b  = lcg_next(pins_a);
    rst_on  = 10'h37f;
    gpio_on = 21'h100000;
    // Reset values
    add_step("chip id", op_read, idx_chip_id, 4'hf, '0, chip_id_value, '0, '0);
    add_step("rst reset", op_read, idx_glbl_rst, 4'hf, '0, '0, '0, '0);
    add_step("mask reset", op_read, idx_glbl_mask, 4'hf, '0, '0, '0, '0);
    add_step("stat reset", op_read, idx_glbl_stat, 4'hf, '0, '0, '0, '0);
    add_step("gpio in reset", op_read, idx_gpio_in, 4'hf, '0, '0, '0, '0);
    add_step("gpio out reset", op_read, idx_gpio_out, 4'hf, '0, '0, '0, '0);
    add_step("gpio dir reset", op_read, idx_gpio_dir, 4'hf, '0, '0, '0, '0);
    add_step("gpio stat reset", op_read, idx_gpio_stat, 4'hf, '0, '0, '0, '0);
    add_step("gpio mask reset", op_read, idx_gpio_mask, 4'hf, '0, '0, '0, '0);
    // Reset release and byte lanes
    add_step("rst write", op_write, idx_glbl_rst, 4'h3, 32'h0000_037f, '0, rst_on, '0);
    add_step("rst read", op_read, idx_glbl_rst, 4'hf, '0, 32'h0000_037f, rst_on, '0);
    add_step("out full", op_write, idx_gpio_out, 4'hf, 32'h1122_3344, '0, rst_on, '0);
    add_step("out lanes", op_write, idx_gpio_out, 4'h5, 32'haabb_ccdd, '0, rst_on, '0);
    add_step("out read", op_read, idx_gpio_out, 4'hf, '0, 32'h11bb_33dd, rst_on, '0);
    add_step("dir lanes", op_write, idx_gpio_dir, 4'ha, 32'hffff_ffff, '0, rst_on, '0);
    add_step("dir read", op_read, idx_gpio_dir, 4'hf, '0, 32'hff00_ff00, rst_on, '0);
    add_step("hole 2", op_read, 5'd2, 4'hf, '0, '0, rst_on, '0);
    add_step("hole 8 wr", op_write, 5'd8, 4'hf, 32'hffff_ffff, '0, rst_on, '0);
    add_step("hole 8", op_read, 5'd8, 4'hf, '0, '0, rst_on, '0);
    add_step("hole 31", op_read, 5'd31, 4'hf, '0, '0, rst_on, '0);
    // Pin synchroniser
    add_step("pins a", op_pins, idx_gpio_in, 4'hf, pins_a, pins_a, rst_on, '0);
    add_step("pins a read", op_read, idx_gpio_in, 4'hf, '0, pins_a, rst_on, '0);
    add_step("pins b", op_pins, idx_gpio_in, 4'hf, pins_b, pins_b, rst_on, '0);
    add_step("pins b read", op_read, idx_gpio_in, 4'hf, '0, pins_b, rst_on, '0);
    // GPIO interrupt status, mask, clear and set alias
    add_step("gpio event", op_gpio_evt, idx_gpio_stat, 4'hf, 32'h8100_0005, '0, rst_on, '0);
    add_step("gpio stat", op_read, idx_gpio_stat, 4'hf, '0, 32'h8100_0005, rst_on, '0);
    add_step("gpio mask", op_write, idx_gpio_mask, 4'hf, 32'h0000_0004, '0, rst_on, gpio_on);
    add_step("clr lane 3", op_write, idx_gpio_stat, 4'h8, 32'h8000_0004, '0, rst_on, gpio_on);
    add_step("stat lane 3", op_read, idx_gpio_stat, 4'hf, '0, 32'h0100_0005, rst_on, gpio_on);
    add_step("clr lane 0", op_write, idx_gpio_stat, 4'h1, 32'h0000_0005, '0, rst_on, '0);
    add_step("stat lane 0", op_read, idx_gpio_stat, 4'hf, '0, 32'h0100_0000, rst_on, '0);
    add_step("gpio set", op_write, idx_gpio_set, 4'hf, 32'h0000_0030, '0, rst_on, '0);
    add_step("set alias", op_read, idx_gpio_set, 4'hf, '0, 32'h0100_0030, rst_on, '0);
    add_step("set stat", op_read, idx_gpio_stat, 4'hf, '0, 32'h0100_0030, rst_on, '0);
    // Global status, gpio source left bit 15 pending
    add_step("glbl gpio", op_read, idx_glbl_stat, 4'hf, '0, 32'h0000_8000, rst_on, '0);
    add_step("glbl clr 15", op_write, idx_glbl_stat, 4'h2, 32'h0000_8000, '0, rst_on, '0);
    add_step("glbl clear", op_read, idx_glbl_stat, 4'hf, '0, '0, rst_on, '0);
    // usb is status bit 12
    add_step("usb pulse", op_usb_evt, idx_glbl_stat, 4'hf, '0, '0, rst_on, '0);
    add_step("usb sticky", op_read, idx_glbl_stat, 4'hf, '0, 32'h0000_1000, rst_on, '0);
    add_step("glbl mask", op_write, idx_glbl_mask, 4'h7, 32'h0001_1000, '0, rst_on, 21'h01000);
    add_step("soft set", op_write, idx_glbl_stat, 4'h4, 32'h0001_0000, '0, rst_on, 21'h11000);
    add_step("soft read", op_read, idx_glbl_stat, 4'hf, '0, 32'h0001_1000, rst_on, 21'h11000);
    add_step("usb clr", op_write, idx_glbl_stat, 4'h2, 32'h0000_1000, '0, rst_on, 21'h10000);
    add_step("usb gone", op_read, idx_glbl_stat, 4'hf, '0, 32'h0001_0000, rst_on, 21'h10000);
  endtask

  task automatic run_step(input int n);
    step_t     s;
    string     name;
    reg_data_t rdata;
    s    = steps[n];
    name = step_names[n];
    case (s.op)
      op_read: begin
        bus_access(1'b0, s.idx, s.be, s.data, rdata);
        check_data(name, s.exp_rdata, rdata);
        // Read-back must match the pins driven by the bank
        case (s.idx)
          idx_gpio_in:  check_data({name, " cfg"}, s.exp_rdata, cfg_gpio_data_in);
          idx_gpio_out: check_data({name, " cfg"}, s.exp_rdata, cfg_gpio_out_data);
          idx_gpio_dir: check_data({name, " cfg"}, s.exp_rdata, cfg_gpio_dir_sel);
          default: ;
        endcase
      end
      op_write:    bus_access(1'b1, s.idx, s.be, s.data, rdata);
      op_pins: begin
        drive_pins(s.data);
        // Second stage is one edge ahead of the readable copy
        check_data({name, " prev"}, s.exp_rdata, gpio_prev_indata);
        repeat (2) @(posedge mclk);
        #1;
        check_data(name, s.exp_rdata, cfg_gpio_data_in);
      end
      op_gpio_evt: pulse_gpio_event(s.data);
      op_usb_evt:  pulse_usb();
      default:     abort_run("unknown operation in the test table");
    endcase
    check_resets(name, s.exp_rst, rst_vector());
    check_irqs(name, s.exp_irq, irq_vector());
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    h_reset_n      = 1'b0;
    reg_cs         = 1'b0;
    reg_wr         = 1'b0;
    reg_addr       = '0;
    reg_wdata      = '0;
    reg_be         = '0;
    ext_intr_in    = '0;
    usb_intr       = 1'b0;
    i2cm_intr      = 1'b0;
    timer_intr     = '0;
    gpio_in_data   = '0;
    gpio_int_event = '0;
    build_table();
    cycle_limit = reset_cycles + cycles_per_step * steps.size();
    repeat (reset_cycles) @(posedge mclk);
    #1;
    h_reset_n = 1'b1;
    // Bus idle after reset
    check_data("reset rdata", '0, reg_rdata);
    if (reg_ack !== 1'b0) begin
      abort_run("reg_ack is not low after reset");
    end
    foreach (steps[n]) begin
      run_step(n);
    end
    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

// File: pinmux_reg.f
source/pinmux_reg_pkg.sv
source/pinmux_reg_bus.sv
source/intr_stat_reg.sv
source/glbl_ctrl_regs.sv
source/gpio_regs.sv
source/pinmux_reg.sv
tests/pinmux_reg_assertions.sv
tests/tb_pinmux_reg.sv

// File: Makefile
# Verilator flow for the pinmux register block
# Override any variable on the command line, e.g. make sim OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_pinmux_reg
FLIST     ?= pinmux_reg.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/100ps
PASS_MSG  ?= PASS: all tests

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	if echo "$$out" | grep -qx "$(PASS_MSG)"; then \
		echo "simulation passed"; \
	else \
		echo "simulation did not pass"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR)
